//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int ADDR_WIDTH       = 6;  // 64 words
    localparam int DATA_WIDTH       = 8;  // One instruction per word
    localparam int OP_WIDTH         = 2;  // Top bits of the word
    localparam int PC_SELECT_SIZE   = 3;  // Room for more PC sources
    localparam int ADDR_SELECT_SIZE = 2;

    // Opcodes, 11 runs as a NOP
    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP  = 2'b00,
        OP_JMP  = 2'b01,
        OP_HLT  = 2'b10,
        OP_RSVD = 2'b11
    } opcode_e;

    // PC mux, unlisted codes hold
    typedef enum logic [PC_SELECT_SIZE-1:0] {
        PC_SRC_HOLD   = 3'b000,
        PC_SRC_INC    = 3'b001,
        PC_SRC_VECTOR = 3'b010,
        PC_SRC_JUMP   = 3'b011
    } pc_src_e;

    // MAR mux, unlisted codes give zero
    typedef enum logic [ADDR_SELECT_SIZE-1:0] {
        ADDR_SRC_PC     = 2'b00,
        ADDR_SRC_TARGET = 2'b01
    } addr_src_e;

    // Sequencer main states
    typedef enum logic [2:0] {
        ST_RESET  = 3'd0,
        ST_READY  = 3'd1,
        ST_F_ADDR = 3'd2,
        ST_F_DATA = 3'd3,
        ST_EXEC   = 3'd4,
        ST_HALT   = 3'd5
    } state_e;

    // Opcode field of an instruction word
    function automatic opcode_e instr_op(input logic [DATA_WIDTH-1:0] word);
        return opcode_e'(word[DATA_WIDTH-1 -: OP_WIDTH]);
    endfunction

    // Jump target, low address bits
    function automatic logic [ADDR_WIDTH-1:0] instr_target(input logic [DATA_WIDTH-1:0] word);
        return word[ADDR_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

//--- verilog/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Datapath strobes from the control matrix
// Strobes are active low and act on the next rising edge
interface ctrl_if;

    logic                pc_rst_n;   // PC clear
    logic                pc_ld_n;    // PC load
    cpu_pkg::pc_src_e    pc_src;     // PC mux select
    logic                mar_rst_n;  // MAR clear
    logic                mar_ld_n;   // MAR load
    cpu_pkg::addr_src_e  addr_src;   // MAR mux select

    // Sequencer side
    modport control (
        output pc_rst_n, pc_ld_n, pc_src,
        output mar_rst_n, mar_ld_n, addr_src
    );

    // Register side
    modport datapath (
        input pc_rst_n, pc_ld_n, pc_src,
        input mar_rst_n, mar_ld_n, addr_src
    );

endinterface

`default_nettype wire

//--- verilog/control_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module control_matrix (
    input  logic                           clk_i,
    input  logic                           resetComplete,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] instr,   // Word fetched in F_DATA
    ctrl_if.control                        ctrl,
    output logic                           ready,   // One cycle after reset vector
    output logic                           halted   // Parked in HALT
);

    // Reset vector sub-steps
    typedef enum logic [1:0] {
        V1 = 2'b00,  // PC <- vector, MAR <- 0
        V2 = 2'b01,  // MAR <- PC
        V3 = 2'b10,  // Wait
        V4 = 2'b11   // Done
    } vec_e;

    cpu_pkg::state_e state_q;
    cpu_pkg::state_e state_d;
    vec_e            vec_q;
    vec_e            vec_d;

    cpu_pkg::opcode_e op;

    assign op = cpu_pkg::instr_op(instr);  // Only looked at in EXEC

    // ------------------------------
    // Next state and strobes
    // ------------------------------
    always_comb begin
        // Hold by default
        state_d = state_q;
        vec_d   = vec_q;

        // All strobes inactive
        ctrl.pc_rst_n  = 1'b1;
        ctrl.pc_ld_n   = 1'b1;
        ctrl.pc_src    = cpu_pkg::PC_SRC_HOLD;
        ctrl.mar_rst_n = 1'b1;
        ctrl.mar_ld_n  = 1'b1;
        ctrl.addr_src  = cpu_pkg::ADDR_SRC_PC;

        ready  = 1'b0;
        halted = 1'b0;

        case (state_q)
            // Vector sequence only runs once reset is released
            cpu_pkg::ST_RESET: begin
                if (!resetComplete) begin
                    case (vec_q)
                        V1: begin
                            ctrl.pc_src    = cpu_pkg::PC_SRC_VECTOR;
                            ctrl.pc_ld_n   = 1'b0;  // PC <- vector
                            ctrl.mar_rst_n = 1'b0;  // MAR <- 0
                            vec_d          = V2;
                        end
                        V2: begin
                            ctrl.addr_src = cpu_pkg::ADDR_SRC_PC;
                            ctrl.mar_ld_n = 1'b0;   // MAR <- PC
                            vec_d         = V3;
                        end
                        V3: begin
                            vec_d = V4;             // Settle cycle
                        end
                        V4: begin
                            vec_d   = V1;           // Rearm for next reset
                            state_d = cpu_pkg::ST_READY;
                        end
                        default: begin
                            vec_d = V1;
                        end
                    endcase
                end
            end

            cpu_pkg::ST_READY: begin
                ready   = 1'b1;                     // Single cycle flag
                state_d = cpu_pkg::ST_F_ADDR;
            end

            // ------------------------------
            // Fetch and execute loop
            // ------------------------------
            cpu_pkg::ST_F_ADDR: begin
                ctrl.addr_src = cpu_pkg::ADDR_SRC_PC;
                ctrl.mar_ld_n = 1'b0;               // MAR <- PC
                state_d       = cpu_pkg::ST_F_DATA;
            end

            cpu_pkg::ST_F_DATA: begin
                // Memory registers word at MAR on this edge
                ctrl.pc_src  = cpu_pkg::PC_SRC_INC;
                ctrl.pc_ld_n = 1'b0;                // PC <- PC + 1
                state_d      = cpu_pkg::ST_EXEC;
            end

            cpu_pkg::ST_EXEC: begin
                case (op)
                    cpu_pkg::OP_JMP: begin
                        ctrl.pc_src  = cpu_pkg::PC_SRC_JUMP;
                        ctrl.pc_ld_n = 1'b0;        // PC <- target
                        state_d      = cpu_pkg::ST_F_ADDR;
                    end
                    cpu_pkg::OP_HLT: begin
                        state_d = cpu_pkg::ST_HALT;
                    end
                    default: begin
                        state_d = cpu_pkg::ST_F_ADDR;  // NOP and reserved
                    end
                endcase
            end

            cpu_pkg::ST_HALT: begin
                halted  = 1'b1;
                state_d = cpu_pkg::ST_HALT;         // Only reset leaves
            end

            default: begin
                // Illegal code, clear datapath and restart the vector
                ctrl.pc_rst_n  = 1'b0;
                ctrl.mar_rst_n = 1'b0;
                state_d        = cpu_pkg::ST_RESET;
                vec_d          = V1;
            end
        endcase
    end

    // ------------------------------
    // State registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            state_q <= cpu_pkg::ST_RESET;
            vec_q   <= V1;
        end else begin
            state_q <= state_d;
            vec_q   <= vec_d;    // Only moves inside RESET
        end
    end

endmodule

`default_nettype wire

//--- verilog/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter #(
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_VECTOR = '0
) (
    input  logic                           clk_i,
    input  logic                           resetComplete,
    ctrl_if.datapath                       ctrl,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] instr,   // Source of jump target
    output logic [cpu_pkg::ADDR_WIDTH-1:0] pc
);

    logic [cpu_pkg::ADDR_WIDTH-1:0] pc_next;

    // ------------------------------
    // Source mux
    // ------------------------------
    always_comb begin
        case (ctrl.pc_src)
            cpu_pkg::PC_SRC_INC:    pc_next = pc + 1'b1;      // Wraps at 64
            cpu_pkg::PC_SRC_VECTOR: pc_next = RESET_VECTOR;
            cpu_pkg::PC_SRC_JUMP:   pc_next = cpu_pkg::instr_target(instr);
            default:                pc_next = pc;             // Hold
        endcase
    end

    // Clear wins over load
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            pc <= '0;
        end else if (!ctrl.pc_rst_n) begin
            pc <= '0;
        end else if (!ctrl.pc_ld_n) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/address_register.sv
`timescale 1ns/1ps
`default_nettype none

module address_register (
    input  logic                           clk_i,
    input  logic                           resetComplete,
    ctrl_if.datapath                       ctrl,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] pc,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] instr,  // Operand target
    output logic [cpu_pkg::ADDR_WIDTH-1:0] mar
);

    logic [cpu_pkg::ADDR_WIDTH-1:0] addr_next;

    // Address mux, target path reserved for operand fetch
    always_comb begin
        case (ctrl.addr_src)
            cpu_pkg::ADDR_SRC_PC:     addr_next = pc;
            cpu_pkg::ADDR_SRC_TARGET: addr_next = cpu_pkg::instr_target(instr);
            default:                  addr_next = '0;
        endcase
    end

    // Clear has priority
    always_ff @(posedge clk_i) begin
        if (resetComplete) begin
            mar <= '0;
        end else if (!ctrl.mar_rst_n) begin
            mar <= '0;
        end else if (!ctrl.mar_ld_n) begin
            mar <= addr_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instr_memory.sv
`timescale 1ns/1ps
`default_nettype none

module instr_memory (
    input  logic                           clk_i,
    input  logic                           we,      // Program load strobe
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] waddr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] raddr,   // Driven by the MAR
    output logic [cpu_pkg::DATA_WIDTH-1:0] instr
);

    localparam int DEPTH = 2 ** cpu_pkg::ADDR_WIDTH;

    // ------------------------------
    // Storage
    // ------------------------------
    logic [cpu_pkg::DATA_WIDTH-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk_i) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read every clock, one cycle latency
    // Same address write returns the old word
    always_ff @(posedge clk_i) begin
        instr <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_VECTOR = '0
) (
    input  logic                           clk_i,
    input  logic                           resetComplete,
    // Program load
    input  logic                           prog_we,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] prog_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] prog_data,
    // Status
    output logic                           ready,
    output logic                           halted,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] pc,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] mar
);

    logic [cpu_pkg::DATA_WIDTH-1:0] instr;  // Registered memory word

    // Strobe bus, sequencer to registers
    ctrl_if ctrl_bus ();

    // ------------------------------
    // Control
    // ------------------------------
    control_matrix i_ctrl (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .instr         (instr),
        .ctrl          (ctrl_bus.control),
        .ready         (ready),
        .halted        (halted)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    program_counter #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_pc (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl          (ctrl_bus.datapath),
        .instr         (instr),
        .pc            (pc)
    );

    address_register i_mar (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .ctrl          (ctrl_bus.datapath),
        .pc            (pc),
        .instr         (instr),
        .mar           (mar)
    );

    // Write port free for the program loader
    instr_memory i_imem (
        .clk_i (clk_i),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (mar),
        .instr (instr)
    );

endmodule

`default_nettype wire

//--- tb/fetch_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sva (
    input logic            clk_i,
    input logic            resetComplete,
    input cpu_pkg::state_e state,
    input logic            pc_rst_n,
    input logic            pc_ld_n,
    input logic            mar_rst_n,
    input logic            mar_ld_n,
    input logic            ready,
    input logic            halted
);

    logic in_fetch;
    logic strobes_idle;

    assign in_fetch     = (state == cpu_pkg::ST_F_ADDR) || (state == cpu_pkg::ST_F_DATA);
    assign strobes_idle = pc_rst_n && pc_ld_n && mar_rst_n && mar_ld_n;

    // Load never paired with clear in the fetch steps
    a_load_vs_clear: assert property (@(posedge clk_i)
        in_fetch |-> !(!pc_ld_n && !pc_rst_n) && !(!mar_ld_n && !mar_rst_n))
        else $error("load and clear strobes low together in a fetch step");

    a_halt_sticky: assert property (@(posedge clk_i) disable iff (resetComplete)
        halted |=> halted)
        else $error("halted dropped without reset");

    a_ready_pulse: assert property (@(posedge clk_i) ready |=> !ready)
        else $error("ready high for two cycles");

    // First reset edge still sees the old state
    a_reset_idle: assert property (@(posedge clk_i)
        resetComplete && $past(resetComplete) |-> strobes_idle && !ready && !halted)
        else $error("strobe or status active during reset");

endmodule

bind control_matrix fetch_sva i_sva (
    .clk_i         (clk_i),
    .resetComplete (resetComplete),
    .state         (state_q),
    .pc_rst_n      (ctrl.pc_rst_n),
    .pc_ld_n       (ctrl.pc_ld_n),
    .mar_rst_n     (ctrl.mar_rst_n),
    .mar_ld_n      (ctrl.mar_ld_n),
    .ready         (ready),
    .halted        (halted)
);

`default_nettype wire

//--- tb/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

    localparam int AW         = cpu_pkg::ADDR_WIDTH;
    localparam int DW         = cpu_pkg::DATA_WIDTH;
    localparam int DEPTH      = 2 ** AW;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_HOLD = 2;
    localparam int NUM_ROWS   = 7;
    localparam int MARGIN     = 40;       // Spare cycles for the watchdog
    localparam logic [AW-1:0] VEC = 6'd4;

    logic          clk_i;
    logic          resetComplete;
    logic          prog_we;
    logic [AW-1:0] prog_addr;
    logic [DW-1:0] prog_data;
    logic          ready;
    logic          halted;
    logic [AW-1:0] pc;
    logic [AW-1:0] mar;

    // ------------------------------
    // Test table and model results
    // ------------------------------
    string         row_name  [NUM_ROWS];
    logic [63:0]   row_words [NUM_ROWS];  // Word i sits at VEC+i with the top byte first
    int            row_len   [NUM_ROWS];  // Words used and the rest become filler NOPs
    bit            row_rnd   [NUM_ROWS];  // LFSR built chain
    int            row_cut   [NUM_ROWS];  // Cycles after ready to a mid-run reset
    int            row_n     [NUM_ROWS];  // Expected instruction count or -1 for model only
    logic [DW-1:0] image     [NUM_ROWS][DEPTH];
    int            exp_n     [NUM_ROWS];
    logic [AW-1:0] exp_mar   [NUM_ROWS];  // Address of the HLT

    logic [15:0]   lfsr_q;
    int            edge_count;            // Rising edges since release
    int            budget_cycles;
    bit            budget_done;

    fetch_top #(
        .RESET_VECTOR (VEC)
    ) i_dut (
        .clk_i         (clk_i),
        .resetComplete (resetComplete),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .ready         (ready),
        .halted        (halted),
        .pc            (pc),
        .mar           (mar)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 16'hB400;
        return n;
    endfunction

    function automatic logic [7:0] take_bits(input int nbits);
        logic [7:0] v;
        int         i;
        v = '0;
        for (i = 0; i < nbits; i++) begin
            v[i]   = lfsr_q[0];           // One step per bit
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_val(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s %s expected %0d actual %0d", test, what, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic set_row(input int r, input string name, input logic [63:0] words,
                           input int len, input bit rnd, input int cut, input int n);
        row_name[r]  = name;
        row_words[r] = words;
        row_len[r]   = len;
        row_rnd[r]   = rnd;
        row_cut[r]   = cut;
        row_n[r]     = n;
    endtask

    // ------------------------------
    // Memory image per row
    // ------------------------------
    task automatic build_image(input int r);
        int            i;
        int            m;
        logic [7:0]    v;
        logic [AW-1:0] t;
        for (i = 0; i < DEPTH; i++) begin
            image[r][i] = {2'b10, i[AW-1:0]};          // HLT tagged with its address
        end
        for (i = 0; i < 8; i++) begin
            v = take_bits(6);
            image[r][VEC + i] = (i < row_len[r]) ? row_words[r][63 - 8*i -: 8]
                                                 : {2'b00, v[5:0]};  // Filler NOP
        end
        if (row_rnd[r]) begin
            v = take_bits(2);
            m = v;                                      // Leading NOPs
            for (i = 0; i < m; i++) begin
                v = take_bits(6);
                image[r][VEC + i] = {2'b00, v[5:0]};
            end
            v = take_bits(5);
            t = 6'd16 + v[4:0];                         // Clear of the program slots
            image[r][VEC + m] = {2'b01, t};
            v = take_bits(2);
            m = v;                                      // NOPs at the target
            for (i = 0; i < m; i++) begin
                v = take_bits(6);
                image[r][t + i] = {2'b00, v[5:0]};
            end
            v = take_bits(6);
            image[r][t + m] = {2'b10, v[5:0]};
        end
    endtask

    // Walk from the vector one instruction per step
    task automatic model_row(input int r);
        logic [AW-1:0] a;
        logic [DW-1:0] w;
        bit            found;
        a        = VEC;
        found    = 1'b0;
        exp_n[r] = 0;
        while (!found && exp_n[r] < DEPTH) begin
            w = image[r][a];
            exp_n[r]++;
            case (w[DW-1 -: 2])
                2'b10:   found = 1'b1;
                2'b01:   a = w[AW-1:0];                 // JMP to low bits
                default: a = a + 1'b1;                  // NOP and reserved
            endcase
        end
        assert (found) else fail_stop($sformatf("no HLT reachable in %s", row_name[r]));
        exp_mar[r] = a;
        if (row_n[r] >= 0) check_val(row_name[r], "model count", row_n[r], exp_n[r]);
    endtask

    // ------------------------------
    // Run steps
    // ------------------------------
    task automatic hold_reset(input int r);
        resetComplete = 1'b1;
        repeat (RESET_HOLD) begin
            @(negedge clk_i);
            check_val(row_name[r], "ready in reset", 0, ready);
            check_val(row_name[r], "halted in reset", 0, halted);
            check_val(row_name[r], "pc in reset", 0, pc);
            check_val(row_name[r], "mar in reset", 0, mar);
        end
    endtask

    task automatic load_program(input int r);
        int a;
        for (a = 0; a < DEPTH; a++) begin
            @(negedge clk_i);
            resetComplete = 1'b1;
            prog_we       = 1'b1;
            prog_addr     = a[AW-1:0];
            prog_data     = image[r][a];
        end
        @(negedge clk_i);
        prog_we = 1'b0;
        hold_reset(r);
    endtask

    task automatic start_run(input int r);
        resetComplete = 1'b0;
        edge_count    = 0;
        while (ready !== 1'b1 && edge_count < 8) begin
            @(negedge clk_i);
            edge_count++;
        end
        assert (ready === 1'b1) else fail_stop({"ready never rose in ", row_name[r]});
        check_val(row_name[r], "ready cycle", 5, edge_count + 1);
        check_val(row_name[r], "pc at ready", VEC, pc);
        check_val(row_name[r], "mar at ready", VEC, mar);
    endtask

    task automatic finish_run(input int r);
        int            halt_edge;
        logic [AW-1:0] pc_after;
        halt_edge = 5 + 3 * exp_n[r];                   // Cycle 5 + 3n + 1
        pc_after  = exp_mar[r] + 1'b1;                  // HLT address plus one
        while (halted !== 1'b1 && edge_count < halt_edge + 8) begin
            @(negedge clk_i);
            edge_count++;
        end
        assert (halted === 1'b1) else fail_stop({"halted never rose in ", row_name[r]});
        check_val(row_name[r], "halt cycle", halt_edge + 1, edge_count + 1);
        check_val(row_name[r], "pc at halt", pc_after, pc);
        check_val(row_name[r], "mar at halt", exp_mar[r], mar);
    endtask

    task automatic run_row(input int r);
        load_program(r);
        start_run(r);
        if (row_cut[r] > 0) begin
            repeat (row_cut[r]) @(negedge clk_i);
            hold_reset(r);                              // Drop into reset mid-loop
            start_run(r);
        end
        finish_run(r);
    endtask

    initial begin
        int r;
        clk_i         = 1'b0;
        resetComplete = 1'b1;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        lfsr_q        = 16'd49;
        budget_cycles = MARGIN;
        budget_done   = 1'b0;
        set_row(0, "halt_at_vector", 64'h80_00_00_00_00_00_00_00, 1, 0, 0, 1);
        set_row(1, "nop_run",        64'h00_00_00_80_00_00_00_00, 4, 0, 0, 4);
        set_row(2, "reserved_nop",   64'hC5_00_80_00_00_00_00_00, 3, 0, 0, 3);
        set_row(3, "jump_to_hlt",    64'h00_68_00_00_00_00_00_00, 2, 0, 0, 3);
        set_row(4, "random_a",       64'h0,                       0, 1, 0, -1);
        set_row(5, "random_b",       64'h0,                       0, 1, 0, -1);
        set_row(6, "reset_mid_run",  64'h00_00_00_00_00_00_00_80, 8, 0, 7, 8);
        for (r = 0; r < NUM_ROWS; r++) begin
            build_image(r);
            model_row(r);
            budget_cycles += DEPTH + 1 + RESET_HOLD + 6 + 3 * exp_n[r];
            if (row_cut[r] > 0) budget_cycles += row_cut[r] + RESET_HOLD + 5;
        end
        budget_done = 1'b1;
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("all tests passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (budget_done);
        #(budget_cycles * CLK_PERIOD);
        fail_stop("watchdog expired before the last test finished");
    end

endmodule

`default_nettype wire

//--- build.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/control_matrix.sv
verilog/program_counter.sv
verilog/address_register.sv
verilog/instr_memory.sv
verilog/fetch_top.sv
tb/fetch_sva.sv
tb/fetch_tb.sv
